// File: Makefile
VERILATOR ?= verilator
TOP       ?= store_unit_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/dmem_bank.sv
`timescale 1ns/1ps

module dmem_bank (
    input  logic                         clk,
    input  logic                         we,
    input  logic [3:0]                   wea,
    input  logic [31:0]                  waddr,
    input  logic [31:0]                  wdata,
    input  logic [store_pkg::DMEM_AW-1:0] rd_addr,
    output logic [31:0]                  rd_data
);

    logic [31:0] mem [store_pkg::DMEM_WORDS];

    store_pkg::store_addr_u waddr_u;

    assign waddr_u = waddr;

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (wea[b]) begin
                    mem[waddr_u.mem_view.word][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,
    input  logic [31:0] io_addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  wea,
    output logic [31:0] leds,
    output logic [31:0] tx_duty,
    output logic [31:0] tx_word,
    output logic [31:0] dac_source,
    output logic [31:0] sine_scale,
    output logic [31:0] square_scale,
    output logic [31:0] tri_scale,
    output logic [31:0] saw_scale,
    output logic [31:0] fcw,
    output logic        uart_tx_we,
    output logic [7:0]  uart_tx_data,
    output logic        counter_reset,
    output logic        gsr,
    output logic        note_start,
    output logic        note_release
);

    store_pkg::store_addr_u io_u;
    logic [12:0]            off;
    logic                   wr;
    logic                   any;

    function automatic logic [31:0] merge(input logic [31:0] old_val,
                                          input logic [31:0] new_val,
                                          input logic [3:0]  mask);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign io_u = io_addr;
    assign off  = io_u.io_view.offset;
    assign wr   = we && io_u.io_view.io;
    assign any  = wr && (|wea);

    always_ff @(posedge clk) begin
        if (rst) begin
            leds          <= '0;
            tx_duty       <= '0;
            tx_word       <= '0;
            dac_source    <= '0;
            sine_scale    <= '0;
            square_scale  <= '0;
            tri_scale     <= '0;
            saw_scale     <= '0;
            fcw           <= '0;
            uart_tx_we    <= 1'b0;
            uart_tx_data  <= '0;
            counter_reset <= 1'b0;
            gsr           <= 1'b0;
            note_start    <= 1'b0;
            note_release  <= 1'b0;
        end else begin
            // single cycle strobes
            uart_tx_we    <= wr && wea[0] && (off == store_pkg::IO_UART_TX);
            counter_reset <= any && (off == store_pkg::IO_COUNTER_RST);
            gsr           <= any && (off == store_pkg::IO_GSR);
            note_start    <= any && (off == store_pkg::IO_NOTE_START);
            note_release  <= any && (off == store_pkg::IO_NOTE_RELEASE);
            if (wr) begin
                case (off)
                    store_pkg::IO_UART_TX: begin
                        if (wea[0]) begin
                            uart_tx_data <= wdata[7:0];
                        end
                    end
                    store_pkg::IO_LEDS:         leds         <= merge(leds, wdata, wea);
                    store_pkg::IO_TX_DUTY:      tx_duty      <= merge(tx_duty, wdata, wea);
                    store_pkg::IO_TX:           tx_word      <= merge(tx_word, wdata, wea);
                    store_pkg::IO_DAC_SRC:      dac_source   <= merge(dac_source, wdata, wea);
                    store_pkg::IO_SINE_SCALE:   sine_scale   <= merge(sine_scale, wdata, wea);
                    store_pkg::IO_SQUARE_SCALE: square_scale <= merge(square_scale, wdata, wea);
                    store_pkg::IO_TRI_SCALE:    tri_scale    <= merge(tri_scale, wdata, wea);
                    store_pkg::IO_SAW_SCALE:    saw_scale    <= merge(saw_scale, wdata, wea);
                    store_pkg::IO_FCW:          fcw          <= merge(fcw, wdata, wea);
                    default: ;  // not in map
                endcase
            end
        end
    end

endmodule

// File: source/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic        clk,
    input  logic        rst,
    input  logic        st_valid,
    output logic        st_ready,
    input  logic [31:0] st_addr,
    input  logic [31:0] st_data,
    input  logic [2:0]  st_funct3,
    input  logic        pc30,
    output logic        a_valid,
    input  logic        a_ready,
    output logic [31:0] a_addr,
    output logic [31:0] a_data,
    output logic [3:0]  a_mask,
    output logic        a_pc30
);

    logic [31:0] data_c;
    logic [3:0]  mask_c;

    // lane placement from funct3 and the low address bits
    always_comb begin
        mask_c = 4'b0000;
        data_c = st_data;
        case (st_funct3)
            store_pkg::FNC_SB: begin
                mask_c = 4'b0001 << st_addr[1:0];
                data_c = {24'b0, st_data[7:0]} << {st_addr[1:0], 3'b000};
            end
            store_pkg::FNC_SH: begin
                if (st_addr[1]) begin
                    mask_c = 4'b1100;
                    data_c = {st_data[15:0], 16'b0};
                end else begin
                    mask_c = 4'b0011;
                    data_c = {16'b0, st_data[15:0]};
                end
            end
            store_pkg::FNC_SW: begin
                mask_c = 4'b1111;
            end
            default: begin
                mask_c = 4'b0000;  // unsupported width, writes nothing
            end
        endcase
    end

    assign st_ready = !a_valid || a_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_valid <= 1'b0;
        end else if (st_ready) begin
            a_valid <= st_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid && st_ready) begin
            a_addr <= st_addr;
            a_data <= data_c;
            a_mask <= mask_c;
            a_pc30 <= pc30;
        end
    end

    a_mask_legal: assert property (@(posedge clk) disable iff (rst)
        a_valid |-> a_mask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                   4'b0011, 4'b1100, 4'b1111});

endmodule

// File: source/store_pkg.sv
package store_pkg;

    // funct3 store widths
    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    // store target after region decode
    localparam logic [1:0] REGION_NONE = 2'd0;
    localparam logic [1:0] REGION_DMEM = 2'd1;
    localparam logic [1:0] REGION_IMEM = 2'd2;
    localparam logic [1:0] REGION_IO   = 2'd3;

    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;

    // word-aligned offsets inside the I/O block
    localparam logic [12:0] IO_UART_TX      = 13'h0008;
    localparam logic [12:0] IO_COUNTER_RST  = 13'h0018;
    localparam logic [12:0] IO_LEDS         = 13'h0030;
    localparam logic [12:0] IO_TX_DUTY      = 13'h0034;
    localparam logic [12:0] IO_TX           = 13'h0038;
    localparam logic [12:0] IO_DAC_SRC      = 13'h0040;
    localparam logic [12:0] IO_GSR          = 13'h0100;
    localparam logic [12:0] IO_SINE_SCALE   = 13'h0200;
    localparam logic [12:0] IO_SQUARE_SCALE = 13'h0204;
    localparam logic [12:0] IO_TRI_SCALE    = 13'h0208;
    localparam logic [12:0] IO_SAW_SCALE    = 13'h020C;
    localparam logic [12:0] IO_FCW          = 13'h1000;
    localparam logic [12:0] IO_NOTE_START   = 13'h1004;
    localparam logic [12:0] IO_NOTE_RELEASE = 13'h1008;

    // the same store address seen by the memories and by the I/O block
    typedef union packed {
        struct packed {
            logic               io;        // bit 31
            logic               rsvd30;
            logic               imem;      // bit 29
            logic               dmem;      // bit 28
            logic [17:0]        rsvd;
            logic [DMEM_AW-1:0] word;
            logic [1:0]         byte_off;
        } mem_view;
        struct packed {
            logic        io;
            logic [17:0] rsvd;
            logic [12:0] offset;           // byte offset, word aligned
        } io_view;
    } store_addr_u;

endpackage

// File: source/store_route.sv
`timescale 1ns/1ps

module store_route (
    input  logic        clk,
    input  logic        rst,
    input  logic        a_valid,
    output logic        a_ready,
    input  logic [31:0] a_addr,
    input  logic [31:0] a_data,
    input  logic [3:0]  a_mask,
    input  logic        a_pc30,
    output logic        r_dmem_we,
    output logic        r_io_we,
    output logic [31:0] r_addr,
    output logic [31:0] r_data,
    output logic [3:0]  r_mask,
    output logic        imem_valid,
    input  logic        imem_ready,
    output logic [31:0] imem_addr,
    output logic [31:0] imem_data,
    output logic [3:0]  imem_wea
);

    store_pkg::store_addr_u addr_u;
    logic [1:0]             region;
    logic                   take;

    assign addr_u = a_addr;

    // first set region bit wins
    always_comb begin
        if (addr_u.mem_view.io) begin
            region = store_pkg::REGION_IO;
        end else if (addr_u.mem_view.dmem) begin
            region = store_pkg::REGION_DMEM;
        end else if (addr_u.mem_view.imem && a_pc30) begin
            region = store_pkg::REGION_IMEM;
        end else begin
            region = store_pkg::REGION_NONE;  // dropped
        end
    end

    assign a_ready = !imem_valid || imem_ready;
    assign take    = a_valid && a_ready && (|a_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            r_dmem_we  <= 1'b0;
            r_io_we    <= 1'b0;
            imem_valid <= 1'b0;
        end else begin
            r_dmem_we <= take && (region == store_pkg::REGION_DMEM);
            r_io_we   <= take && (region == store_pkg::REGION_IO);
            if (a_ready) begin
                imem_valid <= take && (region == store_pkg::REGION_IMEM);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_valid && a_ready) begin
            r_addr <= a_addr;
            r_data <= a_data;
            r_mask <= a_mask;
        end
    end

    assign imem_addr = r_addr;
    assign imem_data = r_data;
    assign imem_wea  = imem_valid ? r_mask : 4'b0000;

    one_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0({r_dmem_we, r_io_we, imem_valid}));

    // stalled request stays put until taken
    imem_hold: assert property (@(posedge clk) disable iff (rst)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr)
            && $stable(imem_data) && $stable(imem_wea));

endmodule

// File: source/store_unit_top.sv
`timescale 1ns/1ps

module store_unit_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          st_valid,
    output logic                          st_ready,
    input  logic [31:0]                   st_addr,
    input  logic [31:0]                   st_data,
    input  logic [2:0]                    st_funct3,
    input  logic                          pc30,
    output logic                          imem_valid,
    input  logic                          imem_ready,
    output logic [31:0]                   imem_addr,
    output logic [31:0]                   imem_data,
    output logic [3:0]                    imem_wea,
    input  logic [store_pkg::DMEM_AW-1:0] rd_addr,
    output logic [31:0]                   rd_data,
    output logic [31:0]                   leds,
    output logic [31:0]                   tx_duty,
    output logic [31:0]                   tx_word,
    output logic [31:0]                   dac_source,
    output logic [31:0]                   sine_scale,
    output logic [31:0]                   square_scale,
    output logic [31:0]                   tri_scale,
    output logic [31:0]                   saw_scale,
    output logic [31:0]                   fcw,
    output logic                          uart_tx_we,
    output logic [7:0]                    uart_tx_data,
    output logic                          counter_reset,
    output logic                          gsr,
    output logic                          note_start,
    output logic                          note_release
);

    logic        a_valid;
    logic        a_ready;
    logic [31:0] a_addr;
    logic [31:0] a_data;
    logic [3:0]  a_mask;
    logic        a_pc30;

    logic        r_dmem_we;
    logic        r_io_we;
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [3:0]  r_mask;

    store_align u_align (
        .clk       (clk),
        .rst       (rst),
        .st_valid  (st_valid),
        .st_ready  (st_ready),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .st_funct3 (st_funct3),
        .pc30      (pc30),
        .a_valid   (a_valid),
        .a_ready   (a_ready),
        .a_addr    (a_addr),
        .a_data    (a_data),
        .a_mask    (a_mask),
        .a_pc30    (a_pc30)
    );

    store_route u_route (
        .clk        (clk),
        .rst        (rst),
        .a_valid    (a_valid),
        .a_ready    (a_ready),
        .a_addr     (a_addr),
        .a_data     (a_data),
        .a_mask     (a_mask),
        .a_pc30     (a_pc30),
        .r_dmem_we  (r_dmem_we),
        .r_io_we    (r_io_we),
        .r_addr     (r_addr),
        .r_data     (r_data),
        .r_mask     (r_mask),
        .imem_valid (imem_valid),
        .imem_ready (imem_ready),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .imem_wea   (imem_wea)
    );

    dmem_bank u_dmem (
        .clk     (clk),
        .we      (r_dmem_we),
        .wea     (r_mask),
        .waddr   (r_addr),
        .wdata   (r_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    io_regs u_io (
        .clk           (clk),
        .rst           (rst),
        .we            (r_io_we),
        .io_addr       (r_addr),
        .wdata         (r_data),
        .wea           (r_mask),
        .leds          (leds),
        .tx_duty       (tx_duty),
        .tx_word       (tx_word),
        .dac_source    (dac_source),
        .sine_scale    (sine_scale),
        .square_scale  (square_scale),
        .tri_scale     (tri_scale),
        .saw_scale     (saw_scale),
        .fcw           (fcw),
        .uart_tx_we    (uart_tx_we),
        .uart_tx_data  (uart_tx_data),
        .counter_reset (counter_reset),
        .gsr           (gsr),
        .note_start    (note_start),
        .note_release  (note_release)
    );

endmodule

// File: sources.f
source/store_pkg.sv
source/store_align.sv
source/store_route.sv
source/dmem_bank.sv
source/io_regs.sv
source/store_unit_top.sv
testbench/store_unit_tb.sv

// File: testbench/store_unit_tb.sv
`timescale 1ns/1ps

module store_unit_tb;

    localparam int N_FILL      = store_pkg::DMEM_WORDS;
    localparam int N_RANDOM    = 800;
    localparam int CYCLE_LIMIT = 10 * (N_FILL + N_RANDOM) + 200;

    logic                          clk;
    logic                          rst;
    logic                          st_valid;
    logic                          st_ready;
    logic [31:0]                   st_addr;
    logic [31:0]                   st_data;
    logic [2:0]                    st_funct3;
    logic                          pc30;
    logic                          imem_valid;
    logic                          imem_ready;
    logic [31:0]                   imem_addr;
    logic [31:0]                   imem_data;
    logic [3:0]                    imem_wea;
    logic [store_pkg::DMEM_AW-1:0] rd_addr;
    logic [31:0]                   rd_data;
    logic [31:0]                   leds;
    logic [31:0]                   tx_duty;
    logic [31:0]                   tx_word;
    logic [31:0]                   dac_source;
    logic [31:0]                   sine_scale;
    logic [31:0]                   square_scale;
    logic [31:0]                   tri_scale;
    logic [31:0]                   saw_scale;
    logic [31:0]                   fcw;
    logic                          uart_tx_we;
    logic [7:0]                    uart_tx_data;
    logic                          counter_reset;
    logic                          gsr;
    logic                          note_start;
    logic                          note_release;

    // reference model state
    logic [31:0] dmem_m [store_pkg::DMEM_WORDS];
    logic [31:0] reg_m [9];        // leds, tx_duty, tx, dac, sine, square, tri, saw, fcw
    logic [4:0]  pulse_m;          // uart_tx_we, counter_reset, gsr, note_start, note_release
    logic [7:0]  uart_m;
    logic        s1_v;
    logic [31:0] s1_addr;
    logic [31:0] s1_data;
    logic [3:0]  s1_mask;
    logic        s1_pc30;
    logic [1:0]  s2_kind;
    logic [31:0] s2_addr;
    logic [31:0] s2_data;
    logic [3:0]  s2_mask;
    logic        ready_m;
    logic        acc;
    logic [31:0] rd_exp;
    logic        rd_pend;
    logic        rd_check_en;
    logic [31:0] lfsr_state;
    int          err_count;
    int          check_count;
    int          imem_seen;
    int          imem_expected;
    int          cycles;
    int          start_err;

    store_unit_top dut (
        .clk           (clk),
        .rst           (rst),
        .st_valid      (st_valid),
        .st_ready      (st_ready),
        .st_addr       (st_addr),
        .st_data       (st_data),
        .st_funct3     (st_funct3),
        .pc30          (pc30),
        .imem_valid    (imem_valid),
        .imem_ready    (imem_ready),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .imem_wea      (imem_wea),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .leds          (leds),
        .tx_duty       (tx_duty),
        .tx_word       (tx_word),
        .dac_source    (dac_source),
        .sine_scale    (sine_scale),
        .square_scale  (square_scale),
        .tri_scale     (tri_scale),
        .saw_scale     (saw_scale),
        .fcw           (fcw),
        .uart_tx_we    (uart_tx_we),
        .uart_tx_data  (uart_tx_data),
        .counter_reset (counter_reset),
        .gsr           (gsr),
        .note_start    (note_start),
        .note_release  (note_release)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pulse(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] draw(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] byte_bits(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  m);
        return (old_val & ~byte_bits(m)) | (new_val & byte_bits(m));
    endfunction

    function automatic logic [3:0] store_mask(input logic [2:0] f3, input logic [1:0] lo);
        int         size;
        int         first;
        logic [3:0] m;
        case (f3)
            store_pkg::FNC_SB: size = 1;
            store_pkg::FNC_SH: size = 2;
            store_pkg::FNC_SW: size = 4;
            default:           size = 0;  // no lanes written
        endcase
        first = 0;
        if (size != 0) begin
            first = (int'(lo) / size) * size;  // naturally aligned start lane
        end
        m = 4'b0000;
        for (int b = 0; b < 4; b++) begin
            m[b] = (b >= first) && (b < first + size);
        end
        return m;
    endfunction

    // low bytes of rs2 fill the masked lanes in order
    function automatic logic [31:0] store_lanes(input logic [31:0] rs2, input logic [3:0] m);
        logic [31:0] d;
        int          k;
        d = '0;
        k = 0;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                d[b*8 +: 8] = rs2[k*8 +: 8];
                k++;
            end
        end
        return d;
    endfunction

    function automatic logic [1:0] region_of(input logic [31:0] a, input logic pc,
                                             input logic [3:0] m);
        if (m == 4'b0000) begin
            return store_pkg::REGION_NONE;
        end else if (a[31]) begin
            return store_pkg::REGION_IO;
        end else if (a[28]) begin
            return store_pkg::REGION_DMEM;
        end else if (a[29] && pc) begin
            return store_pkg::REGION_IMEM;
        end
        return store_pkg::REGION_NONE;
    endfunction

    function automatic int reg_slot(input logic [12:0] off);
        case (off)
            store_pkg::IO_LEDS:         return 0;
            store_pkg::IO_TX_DUTY:      return 1;
            store_pkg::IO_TX:           return 2;
            store_pkg::IO_DAC_SRC:      return 3;
            store_pkg::IO_SINE_SCALE:   return 4;
            store_pkg::IO_SQUARE_SCALE: return 5;
            store_pkg::IO_TRI_SCALE:    return 6;
            store_pkg::IO_SAW_SCALE:    return 7;
            store_pkg::IO_FCW:          return 8;
            default:                    return -1;
        endcase
    endfunction

    function automatic logic [12:0] io_offset(input logic [3:0] sel);
        case (sel)
            4'd0:    return store_pkg::IO_UART_TX;
            4'd1:    return store_pkg::IO_COUNTER_RST;
            4'd2:    return store_pkg::IO_LEDS;
            4'd3:    return store_pkg::IO_TX_DUTY;
            4'd4:    return store_pkg::IO_TX;
            4'd5:    return store_pkg::IO_DAC_SRC;
            4'd6:    return store_pkg::IO_GSR;
            4'd7:    return store_pkg::IO_SINE_SCALE;
            4'd8:    return store_pkg::IO_SQUARE_SCALE;
            4'd9:    return store_pkg::IO_TRI_SCALE;
            4'd10:   return store_pkg::IO_SAW_SCALE;
            4'd11:   return store_pkg::IO_FCW;
            4'd12:   return store_pkg::IO_NOTE_START;
            4'd13:   return store_pkg::IO_NOTE_RELEASE;
            4'd14:   return 13'h0044;  // hole in the map
            default: return 13'h0ffc;
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, idx ^ 8'hc3, ~idx, idx + 8'h1d};
    endfunction

    task automatic apply_io();
        logic [12:0] off;
        int          slot;
        off  = s2_addr[12:0];
        slot = reg_slot(off);
        if (slot >= 0) begin
            reg_m[slot] = lane_merge(reg_m[slot], s2_data, s2_mask);
        end
        case (off)
            store_pkg::IO_UART_TX: begin
                if (s2_mask[0]) begin
                    pulse_m[0] = 1'b1;
                    uart_m     = s2_data[7:0];
                end
            end
            store_pkg::IO_COUNTER_RST:  pulse_m[1] = 1'b1;
            store_pkg::IO_GSR:          pulse_m[2] = 1'b1;
            store_pkg::IO_NOTE_START:   pulse_m[3] = 1'b1;
            store_pkg::IO_NOTE_RELEASE: pulse_m[4] = 1'b1;
            default: ;
        endcase
    endtask

    task automatic compare_outputs();
        logic [31:0] keep;
        keep = byte_bits(s2_mask);
        check_pulse("st_ready", st_ready, ready_m);
        check_pulse("imem_valid", imem_valid, s2_kind == store_pkg::REGION_IMEM);
        if (s2_kind == store_pkg::REGION_IMEM) begin
            check_word("imem_addr", imem_addr, s2_addr);
            check_mask("imem_wea", imem_wea, s2_mask);
            check_word("imem_data", imem_data & keep, s2_data & keep);
        end
        if (rd_pend) begin
            check_word("rd_data", rd_data, rd_exp);
        end
        check_word("leds", leds, reg_m[0]);
        check_word("tx_duty", tx_duty, reg_m[1]);
        check_word("tx_word", tx_word, reg_m[2]);
        check_word("dac_source", dac_source, reg_m[3]);
        check_word("sine_scale", sine_scale, reg_m[4]);
        check_word("square_scale", square_scale, reg_m[5]);
        check_word("tri_scale", tri_scale, reg_m[6]);
        check_word("saw_scale", saw_scale, reg_m[7]);
        check_word("fcw", fcw, reg_m[8]);
        check_word("uart_tx_data", {24'b0, uart_tx_data}, {24'b0, uart_m});
        check_pulse("uart_tx_we", uart_tx_we, pulse_m[0]);
        check_pulse("counter_reset", counter_reset, pulse_m[1]);
        check_pulse("gsr", gsr, pulse_m[2]);
        check_pulse("note_start", note_start, pulse_m[3]);
        check_pulse("note_release", note_release, pulse_m[4]);
    endtask

    // check what the last edge left and then advance the model by one edge
    task automatic tick();
        logic       stall;
        logic [3:0] m;
        @(posedge clk);
        stall   = (s2_kind == store_pkg::REGION_IMEM) && !imem_ready;
        ready_m = !s1_v || !stall;
        compare_outputs();
        if (imem_valid && imem_ready) begin
            imem_seen++;
        end
        acc     = st_valid && ready_m;
        rd_exp  = dmem_m[rd_addr];  // read sees memory before this edge
        rd_pend = rd_check_en;
        pulse_m = 5'b0;
        case (s2_kind)
            store_pkg::REGION_DMEM: begin
                dmem_m[s2_addr[9:2]] = lane_merge(dmem_m[s2_addr[9:2]], s2_data, s2_mask);
            end
            store_pkg::REGION_IO: apply_io();
            default: ;
        endcase
        if (!stall) begin
            s2_kind = s1_v ? region_of(s1_addr, s1_pc30, s1_mask) : store_pkg::REGION_NONE;
            s2_addr = s1_addr;
            s2_data = s1_data;
            s2_mask = s1_mask;
            if (s2_kind == store_pkg::REGION_IMEM) begin
                imem_expected++;
            end
        end
        if (ready_m) begin
            s1_v = acc;
            if (acc) begin
                m       = store_mask(st_funct3, st_addr[1:0]);
                s1_mask = m;
                s1_data = store_lanes(st_data, m);
                s1_addr = st_addr;
                s1_pc30 = pc30;
            end
        end
    endtask

    task automatic next_store(input logic fill, input logic [7:0] idx);
        logic [31:0] r;
        logic [31:0] lo;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] f;
        logic [31:0] pc;
        if (fill) begin
            a  = {4'b0001, 18'b0, idx, 2'b00};
            d  = fill_word(idx);
            f  = {29'b0, store_pkg::FNC_SW};
            pc = 32'b0;
        end else begin
            r  = draw(2);
            lo = draw(2);
            case (r[1:0])
                2'd0: begin  // data memory with bit 29 sometimes set too
                    r = draw(9);
                    a = {2'b00, r[8], 1'b1, 18'b0, r[7:0], lo[1:0]};
                end
                2'd1: begin
                    r = draw(7);
                    if (r[6]) begin
                        lo = 32'b0;
                    end
                    a = {2'b10, r[5:4], 15'b0, io_offset(r[3:0]) | {11'b0, lo[1:0]}};
                end
                2'd2: begin
                    r = draw(16);
                    a = {4'b0010, 12'b0, r[15:2], lo[1:0]};
                end
                default: begin  // no region bit set
                    r = draw(32);
                    a = {1'b0, r[30], 2'b00, r[27:0]};
                end
            endcase
            d  = draw(32);
            pc = draw(1);
            r  = draw(2);
            case (r[1:0])
                2'd0:    f = {29'b0, store_pkg::FNC_SB};
                2'd1:    f = {29'b0, store_pkg::FNC_SH};
                2'd2:    f = {29'b0, store_pkg::FNC_SW};
                default: f = draw(3);  // any code and mostly illegal
            endcase
        end
        st_valid  <= 1'b1;
        st_addr   <= a;
        st_data   <= d;
        st_funct3 <= f[2:0];
        pc30      <= pc[0];
    endtask

    task automatic drain();
        st_valid   <= 1'b0;
        imem_ready <= 1'b1;
        repeat (5) begin
            tick();
        end
    endtask

    task automatic run_stores(input string name, input logic fill, input int n);
        logic [31:0] r;
        logic        pending;
        int          sent;
        int          first_err;
        sent      = 0;
        pending   = 1'b0;
        first_err = err_count;
        while (sent < n) begin
            if (!pending) begin
                r = draw(3);
                if (fill || r[2:0] != 3'd0) begin
                    next_store(fill, sent[7:0]);
                    pending = 1'b1;
                end else begin
                    st_valid <= 1'b0;
                end
            end
            r = draw(1);
            imem_ready <= r[0];
            r = draw(8);
            rd_addr <= r[store_pkg::DMEM_AW-1:0];
            tick();
            if (pending && acc) begin
                sent++;
                pending = 1'b0;
            end
        end
        drain();
        $display("test %s: %0d stores, %0d errors", name, n, err_count - first_err);
    endtask

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst        = 1'b1;
        st_valid   = 1'b0;
        st_addr    = '0;
        st_data    = '0;
        st_funct3  = '0;
        pc30       = 1'b0;
        imem_ready = 1'b0;
        rd_addr    = '0;
        lfsr_state = 32'h3a66f2d1;
        for (int i = 0; i < store_pkg::DMEM_WORDS; i++) begin
            dmem_m[i] = '0;
        end
        for (int i = 0; i < 9; i++) begin
            reg_m[i] = '0;
        end
        pulse_m       = '0;
        uart_m        = '0;
        s1_v          = 1'b0;
        s2_kind       = store_pkg::REGION_NONE;
        ready_m       = 1'b1;
        acc           = 1'b0;
        rd_pend       = 1'b0;
        rd_check_en   = 1'b0;
        err_count     = 0;
        check_count   = 0;
        imem_seen     = 0;
        imem_expected = 0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        run_stores("dmem_fill", 1'b1, N_FILL);
        rd_check_en = 1'b1;  // every word now known
        run_stores("random_mix", 1'b0, N_RANDOM);

        start_err = err_count;
        for (int i = 0; i < store_pkg::DMEM_WORDS; i++) begin
            rd_addr <= i[store_pkg::DMEM_AW-1:0];
            tick();
        end
        tick();
        check_word("imem_writes", imem_seen, imem_expected);
        $display("test dmem_sweep: %0d reads, %0d errors", store_pkg::DMEM_WORDS,
                 err_count - start_err);

        $display("checks %0d, errors %0d, imem writes %0d of %0d", check_count, err_count,
                 imem_seen, imem_expected);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
